//--- include/qm_defines.svh
`ifndef QM_DEFINES_SVH
`define QM_DEFINES_SVH

`define QM_NUM_VARS       5
`define QM_NUM_MINTERMS   32
`define QM_COL_DEPTH      80     // Widest column, 1 or 2 dashes
`define QM_MAX_PRIMES     32
`define QM_CNT_W          6      // Counts up to QM_MAX_PRIMES
`define QM_IDX_W          7      // Column index width

`define QM_ADDR_ONSET     12'h000
`define QM_ADDR_CTRL      12'h004
`define QM_ADDR_STATUS    12'h008
`define QM_ADDR_RESULT    12'h100

`define QM_STAT_BUSY_BIT  0
`define QM_STAT_DONE_BIT  1
`define QM_STAT_PCNT_LSB  8
`define QM_STAT_ECNT_LSB  16
`define QM_RES_VALUE_LSB  0
`define QM_RES_MASK_LSB   8
`define QM_RES_ESS_BIT    16

`endif

//--- src/qm_pkg.sv
`include "qm_defines.svh"

package qm_pkg;

    ////////////////////////////////////////////////////////////
    // Cube and result types
    ////////////////////////////////////////////////////////////

    // Value bits under a dash stay zero
    typedef struct packed {
        logic [`QM_NUM_VARS-1:0] mask;
        logic [`QM_NUM_VARS-1:0] value;
    } qm_cube_t;

    typedef struct packed {
        qm_cube_t cube;
        logic     essential;
    } qm_prime_t;

    // Merge engine to prime chart
    typedef struct packed {
        logic     valid;
        logic     last;
        qm_cube_t cube;
    } qm_prime_strm_t;

    typedef struct packed {
        logic                 busy;
        logic                 done;
        logic [`QM_CNT_W-1:0] prime_count;
        logic [`QM_CNT_W-1:0] ess_count;
    } qm_run_status_t;

endpackage

//--- src/qm_apb_slave.sv
`timescale 1ns/1ps
`include "qm_defines.svh"

module qm_apb_slave (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [11:0]                 paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic [`QM_NUM_MINTERMS-1:0] onset,
    output logic                        start,
    input  qm_pkg::qm_run_status_t      status,
    output logic [4:0]                  result_index,
    input  qm_pkg::qm_prime_t           result
);

    logic        access;
    logic        hit_onset;
    logic        hit_ctrl;
    logic        hit_status;
    logic        hit_result;
    logic        mapped;
    logic [11:0] res_off;
    logic [31:0] rd_word;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign access  = psel & penable;
    assign res_off = paddr - `QM_ADDR_RESULT;

    assign hit_onset  = (paddr == `QM_ADDR_ONSET);
    assign hit_ctrl   = (paddr == `QM_ADDR_CTRL);
    assign hit_status = (paddr == `QM_ADDR_STATUS);
    assign hit_result = (paddr[1:0] == 2'b00) && (paddr >= `QM_ADDR_RESULT) &&
                        (res_off < 4 * `QM_MAX_PRIMES);
    assign mapped     = hit_onset | hit_ctrl | hit_status | hit_result;

    assign result_index = res_off[6:2]; // Word index into result window

    assign pready  = 1'b1;              // No wait states
    assign pslverr = access & (~mapped | (pwrite & (hit_status | hit_result)));

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            onset <= '0;
            start <= 1'b0;
        end else begin
            start <= access & pwrite & hit_ctrl & pwdata[0] & ~status.busy;
            if (access && pwrite && hit_onset) begin
                onset <= pwdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_word = '0;
        if (hit_onset) begin
            rd_word = onset;
        end else if (hit_status) begin
            // A pending start already counts as busy
            rd_word[`QM_STAT_BUSY_BIT] = status.busy | start;
            rd_word[`QM_STAT_DONE_BIT] = status.done & ~start;
            rd_word[`QM_STAT_PCNT_LSB +: `QM_CNT_W] = status.prime_count;
            rd_word[`QM_STAT_ECNT_LSB +: `QM_CNT_W] = status.ess_count;
        end else if (hit_result) begin
            rd_word[`QM_RES_VALUE_LSB +: `QM_NUM_VARS] = result.cube.value;
            rd_word[`QM_RES_MASK_LSB +: `QM_NUM_VARS]  = result.cube.mask;
            rd_word[`QM_RES_ESS_BIT]                   = result.essential;
        end
    end

    assign prdata = (psel && !pwrite) ? rd_word : '0;

endmodule

//--- src/qm_merge_engine.sv
`timescale 1ns/1ps
`include "qm_defines.svh"

module qm_merge_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [`QM_NUM_MINTERMS-1:0] onset,
    output qm_pkg::qm_prime_strm_t      prime_strm
);

    import qm_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_COL,
        S_PAIR,
        S_EMIT
    } state_t;

    state_t                      state;
    logic [`QM_NUM_MINTERMS-1:0] onset_q;
    qm_cube_t                    col [2][`QM_COL_DEPTH];
    logic                        merged [2][`QM_COL_DEPTH];
    logic [`QM_IDX_W-1:0]        cnt [2];
    logic                        cur;
    logic                        nxt;
    logic [`QM_NUM_VARS-1:0]     load_idx;
    logic [`QM_IDX_W-1:0]        pi;
    logic [`QM_IDX_W-1:0]        pj;
    logic [`QM_IDX_W-1:0]        emit_idx;
    logic                        last_col;
    qm_cube_t                    cube_a;
    qm_cube_t                    cube_b;
    qm_cube_t                    merged_cube;
    logic [`QM_NUM_VARS-1:0]     diff;
    logic                        can_merge;
    logic                        is_dup;
    logic                        strm_valid;
    logic                        strm_last;
    qm_cube_t                    strm_cube;

    ////////////////////////////////////////////////////////////
    // Pair compare
    ////////////////////////////////////////////////////////////

    assign nxt    = ~cur;
    assign cube_a = col[cur][pi];
    assign cube_b = col[cur][pj];
    assign diff   = cube_a.value ^ cube_b.value;

    // Same dashes, exactly one differing bit
    assign can_merge = (cube_a.mask == cube_b.mask) && (diff != '0) &&
                       ((diff & (diff - 1'b1)) == '0);
    assign merged_cube = '{mask: cube_a.mask | diff, value: cube_a.value & ~diff};

    // Duplicate scan over the next column
    always_comb begin
        is_dup = 1'b0;
        for (int p = 0; p < `QM_COL_DEPTH; p++) begin
            if (p < cnt[nxt] && col[nxt][p] == merged_cube) begin
                is_dup = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            cur        <= 1'b0;
            cnt[0]     <= '0;
            cnt[1]     <= '0;
            load_idx   <= '0;
            pi         <= '0;
            pj         <= '0;
            emit_idx   <= '0;
            last_col   <= 1'b0;
            strm_valid <= 1'b0;
            strm_last  <= 1'b0;
        end else begin
            strm_valid <= 1'b0;
            strm_last  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        cur      <= 1'b0;
                        cnt[0]   <= '0;
                        load_idx <= '0;
                        state    <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (onset_q[load_idx]) begin
                        cnt[cur] <= cnt[cur] + 1'b1;
                    end
                    load_idx <= load_idx + 1'b1;
                    if (&load_idx) begin            // Minterm 31 done
                        state <= S_COL;
                    end
                end
                S_COL: begin
                    pi        <= '0;
                    pj        <= `QM_IDX_W'(1);
                    emit_idx  <= '0;
                    cnt[nxt]  <= '0;
                    if (cnt[cur] < `QM_IDX_W'(2)) begin
                        last_col <= 1'b1;           // Nothing to pair
                        state    <= S_EMIT;
                    end else begin
                        last_col <= 1'b0;
                        state    <= S_PAIR;
                    end
                end
                S_PAIR: begin
                    if (can_merge && !is_dup) begin
                        cnt[nxt] <= cnt[nxt] + 1'b1;
                    end
                    if (pj == cnt[cur] - 1'b1) begin
                        if (pi + `QM_IDX_W'(2) >= cnt[cur]) begin
                            // First merge always appends, so empty means no merge
                            last_col <= (cnt[nxt] == '0) && !can_merge;
                            state    <= S_EMIT;
                        end else begin
                            pi <= pi + 1'b1;
                            pj <= pi + `QM_IDX_W'(2);
                        end
                    end else begin
                        pj <= pj + 1'b1;
                    end
                end
                S_EMIT: begin
                    if (cnt[cur] == '0) begin
                        strm_last <= 1'b1;          // Empty onset
                        state     <= S_IDLE;
                    end else begin
                        strm_valid <= !merged[cur][emit_idx];
                        strm_last  <= last_col && (emit_idx == cnt[cur] - 1'b1);
                        if (emit_idx == cnt[cur] - 1'b1) begin
                            emit_idx <= '0;
                            if (last_col) begin
                                state <= S_IDLE;
                            end else begin
                                cur   <= nxt;
                                state <= S_COL;
                            end
                        end else begin
                            emit_idx <= emit_idx + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Column storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            onset_q <= onset;
        end
        if (state == S_LOAD && onset_q[load_idx]) begin
            col[cur][cnt[cur]]    <= '{mask: '0, value: load_idx};
            merged[cur][cnt[cur]] <= 1'b0;
        end
        if (state == S_PAIR && can_merge) begin
            merged[cur][pi] <= 1'b1;
            merged[cur][pj] <= 1'b1;
            if (!is_dup) begin
                col[nxt][cnt[nxt]]    <= merged_cube;
                merged[nxt][cnt[nxt]] <= 1'b0;
            end
        end
        strm_cube <= col[cur][emit_idx];
    end

    assign prime_strm = '{valid: strm_valid, last: strm_last, cube: strm_cube};

endmodule

//--- src/qm_prime_chart.sv
`timescale 1ns/1ps
`include "qm_defines.svh"

module qm_prime_chart (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  qm_pkg::qm_prime_strm_t prime_strm,
    output qm_pkg::qm_run_status_t status,
    input  logic [4:0]             result_index,
    output qm_pkg::qm_prime_t      result
);

    import qm_pkg::*;

    qm_cube_t                    primes [`QM_MAX_PRIMES];
    logic [`QM_MAX_PRIMES-1:0]   ess;
    logic [1:0]                  cover_cnt [`QM_NUM_MINTERMS]; // Saturates at 3
    logic [`QM_CNT_W-1:0]        prime_cnt;
    logic [`QM_CNT_W-1:0]        ess_cnt;
    logic [4:0]                  mark_idx;
    logic                        busy;
    logic                        done;
    logic                        marking;
    logic [`QM_NUM_MINTERMS-1:0] in_cover;
    logic [`QM_NUM_MINTERMS-1:0] mark_cover;
    logic                        mark_ess;

    function automatic logic [`QM_NUM_MINTERMS-1:0] cover_set(qm_cube_t c);
        logic [`QM_NUM_MINTERMS-1:0] s;
        s = '0;
        for (int m = 0; m < `QM_NUM_MINTERMS; m++) begin
            s[m] = ((`QM_NUM_VARS'(m) & ~c.mask) == c.value);
        end
        return s;
    endfunction

    assign in_cover   = cover_set(prime_strm.cube);
    assign mark_cover = cover_set(primes[mark_idx]);

    // Essential if it alone covers some minterm
    always_comb begin
        mark_ess = 1'b0;
        for (int m = 0; m < `QM_NUM_MINTERMS; m++) begin
            if (mark_cover[m] && cover_cnt[m] == 2'd1) begin
                mark_ess = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            busy      <= start;
            done      <= 1'b0;
            marking   <= 1'b0;
            prime_cnt <= '0;
            ess_cnt   <= '0;
            mark_idx  <= '0;
        end else begin
            if (prime_strm.valid) begin
                prime_cnt <= prime_cnt + 1'b1;
            end
            if (prime_strm.last) begin
                if (prime_cnt == '0 && !prime_strm.valid) begin
                    busy <= 1'b0;                   // No primes at all
                    done <= 1'b1;
                end else begin
                    marking <= 1'b1;
                end
            end
            if (marking) begin
                if (mark_ess) begin
                    ess_cnt <= ess_cnt + 1'b1;
                end
                mark_idx <= mark_idx + 1'b1;
                if ({1'b0, mark_idx} == prime_cnt - 1'b1) begin
                    marking <= 1'b0;
                    busy    <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Prime table and cover counts
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            for (int m = 0; m < `QM_NUM_MINTERMS; m++) begin
                cover_cnt[m] <= 2'd0;
            end
        end else if (prime_strm.valid) begin
            primes[prime_cnt[4:0]] <= prime_strm.cube;
            ess[prime_cnt[4:0]]    <= 1'b0;
            for (int m = 0; m < `QM_NUM_MINTERMS; m++) begin
                if (in_cover[m] && cover_cnt[m] != 2'd3) begin
                    cover_cnt[m] <= cover_cnt[m] + 2'd1;
                end
            end
        end
        if (marking) begin
            ess[mark_idx] <= mark_ess;
        end
    end

    assign status = '{busy: busy, done: done, prime_count: prime_cnt, ess_count: ess_cnt};

    always_comb begin
        result = '0;
        if ({1'b0, result_index} < prime_cnt) begin
            result.cube      = primes[result_index];
            result.essential = ess[result_index];
        end
    end

endmodule

//--- src/qm_top.sv
`timescale 1ns/1ps
`include "qm_defines.svh"

module qm_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    import qm_pkg::*;

    logic [`QM_NUM_MINTERMS-1:0] onset;
    logic                        start;
    qm_run_status_t              status;
    logic [4:0]                  result_index;
    qm_prime_t                   result;
    qm_prime_strm_t              prime_strm;

    ////////////////////////////////////////////////////////////
    // Host side
    ////////////////////////////////////////////////////////////

    qm_apb_slave i_qm_apb_slave (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .onset        (onset),
        .start        (start),
        .status       (status),
        .result_index (result_index),
        .result       (result)
    );

    qm_merge_engine i_qm_merge_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .onset      (onset),
        .prime_strm (prime_strm)
    );

    qm_prime_chart i_qm_prime_chart (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .prime_strm   (prime_strm),
        .status       (status),
        .result_index (result_index),
        .result       (result)
    );

endmodule

//--- tests/qm_clk_gen.sv
`timescale 1ns/1ps

module qm_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;         // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tests/qm_asserts.sv
`timescale 1ns/1ps

module qm_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   pready,
    input logic                   start,
    input qm_pkg::qm_run_status_t status
);

    int fail_count = 0;

    a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin
            fail_count++;
            $error("pready went low");
        end

    // Start only from an idle chart
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !status.busy)
        else begin
            fail_count++;
            $error("start pulsed while busy");
        end

    a_done_xor_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(status.done && status.busy))
        else begin
            fail_count++;
            $error("done and busy high together");
        end

endmodule

//--- tests/qm_tb.sv
`timescale 1ns/1ps
`include "qm_defines.svh"

module qm_tb;

    import qm_pkg::*;

    localparam int NUM_RUNS   = 16;     // 3 corner, 12 random, 1 overlap
    localparam int RUN_CYCLES = 20000;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    qm_cube_t    model_primes [$];
    logic        model_ess [$];
    int          model_ess_cnt;
    bit          seen [`QM_MAX_PRIMES];

    qm_clk_gen i_qm_clk_gen (.clk(clk), .rst_n(rst_n));

    qm_top i_qm_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind qm_top qm_asserts i_qm_asserts (
        .clk    (clk),
        .rst_n  (rst_n),
        .pready (pready),
        .start  (start),
        .status (status)
    );

    ////////////////////////////////////////////////////////////
    // Reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                    $time, what, got, exp));
        end
    endtask

    // Entry must be a model prime, unseen so far, with the model's flag
    task automatic check_prime(input int k, input qm_prime_t got);
        int hit;
        hit = -1;
        foreach (model_primes[j]) begin
            if (model_primes[j] == got.cube) begin
                hit = j;
            end
        end
        if (hit < 0) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: RESULT %0d mask %b value %b is no prime",
                                    $time, k, got.cube.mask, got.cube.value));
        end else if (seen[hit]) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: RESULT %0d repeats a prime",
                                    $time, k));
        end else begin
            check_bit($sformatf("RESULT %0d essential", k), got.essential, model_ess[hit]);
            seen[hit] = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] minterms_of(qm_cube_t c);
        logic [31:0] s;
        s = '0;
        for (int m = 0; m < 32; m++) begin
            s[m] = (((5'(m) ^ c.value) & ~c.mask) == 5'b0);
        end
        return s;
    endfunction

    task automatic build_model(input logic [31:0] onset);
        qm_cube_t    c;
        qm_cube_t    wider;
        bit          prime;
        int          covering;
        logic [31:0] prime_sets [$];
        model_primes.delete();
        model_ess.delete();
        model_ess_cnt = 0;
        for (int mk = 0; mk < 32; mk++) begin
            for (int v = 0; v < 32; v++) begin
                c.mask  = 5'(mk);
                c.value = 5'(v);
                if ((c.mask & c.value) == '0 && (minterms_of(c) & ~onset) == '0) begin
                    prime = 1'b1;
                    for (int b = 0; b < 5; b++) begin
                        wider.mask  = c.mask | (5'b1 << b);
                        wider.value = c.value & ~(5'b1 << b);
                        if (!c.mask[b] && (minterms_of(wider) & ~onset) == '0) begin
                            prime = 1'b0;       // Grows by one dash
                        end
                    end
                    if (prime) begin
                        model_primes.push_back(c);
                        prime_sets.push_back(minterms_of(c));
                    end
                end
            end
        end
        foreach (prime_sets[i]) begin
            model_ess.push_back(1'b0);
            for (int m = 0; m < 32; m++) begin
                covering = 0;
                foreach (prime_sets[j]) begin
                    if (prime_sets[j][m]) begin
                        covering++;
                    end
                end
                if (prime_sets[i][m] && covering == 1) begin
                    model_ess[i] = 1'b1;
                end
            end
            if (model_ess[i]) begin
                model_ess_cnt++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB access
    ////////////////////////////////////////////////////////////

    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);                 // Mid access phase
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic write_ok(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check_bit($sformatf("pslverr on write to %h", addr), err, 1'b0);
    endtask

    task automatic read_ok(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_bit($sformatf("pslverr on read from %h", addr), err, 1'b0);
    endtask

    task automatic start_run(input logic [31:0] onset);
        write_ok(`QM_ADDR_ONSET, onset);
        write_ok(`QM_ADDR_CTRL, 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[`QM_STAT_DONE_BIT]) begin
            read_ok(`QM_ADDR_STATUS, st);
        end
    endtask

    // Status, every result entry and the empty tail of the window
    task automatic check_run(input logic [31:0] onset);
        logic [31:0] w;
        logic [31:0] exp;
        qm_prime_t   got;
        build_model(onset);
        exp = (32'(model_ess_cnt) << `QM_STAT_ECNT_LSB) |
              (32'(model_primes.size()) << `QM_STAT_PCNT_LSB) |
              (32'h1 << `QM_STAT_DONE_BIT);
        read_ok(`QM_ADDR_STATUS, w);
        check_word($sformatf("STATUS for onset %h", onset), w, exp);
        for (int k = 0; k < `QM_MAX_PRIMES; k++) begin
            seen[k] = 1'b0;
        end
        for (int k = 0; k < `QM_MAX_PRIMES; k++) begin
            read_ok(12'(`QM_ADDR_RESULT + 4 * k), w);
            if (k < model_primes.size()) begin
                got.cube.value = w[`QM_RES_VALUE_LSB +: 5];
                got.cube.mask  = w[`QM_RES_MASK_LSB +: 5];
                got.essential  = w[`QM_RES_ESS_BIT];
                check_prime(k, got);
            end else begin
                check_word($sformatf("RESULT %0d past count", k), w, '0);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        logic [31:0] w;
        read_ok(`QM_ADDR_STATUS, w);
        check_word("STATUS after reset", w, '0);
        read_ok(`QM_ADDR_ONSET, w);
        check_word("ONSET after reset", w, '0);
    endtask

    task automatic test_register_access();
        logic [31:0] w;
        logic        err;
        write_ok(`QM_ADDR_ONSET, 32'hA5C3_0F96);
        read_ok(`QM_ADDR_ONSET, w);
        check_word("ONSET read-back", w, 32'hA5C3_0F96);
        apb_access(1'b0, 12'h010, '0, w, err);
        check_bit("pslverr on unmapped read", err, 1'b1);
        apb_access(1'b1, `QM_ADDR_STATUS, 32'h3, w, err);
        check_bit("pslverr on STATUS write", err, 1'b1);
        apb_access(1'b1, `QM_ADDR_RESULT, 32'h1, w, err);
        check_bit("pslverr on RESULT write", err, 1'b1);
    endtask

    task automatic run_corner(input logic [31:0] onset, input logic [31:0] first_exp);
        logic [31:0] w;
        start_run(onset);
        wait_done();
        check_run(onset);
        read_ok(`QM_ADDR_RESULT, w);
        check_word($sformatf("RESULT 0 for onset %h", onset), w, first_exp);
    endtask

    task automatic test_corner_onsets();
        logic [4:0] m;
        m = 5'($urandom_range(31, 0));
        run_corner(32'h0, 32'h0);                       // No primes
        run_corner(32'hFFFF_FFFF, 32'h0001_1F00);       // All-dash, essential
        run_corner(32'h1 << m, 32'h0001_0000 | 32'(m));
    endtask

    // Prime count, prime set and essential flags per run
    task automatic test_random_runs();
        logic [31:0] onset;
        for (int i = 0; i < 12; i++) begin
            onset = $urandom();
            if (i % 3 == 0) begin
                onset = onset & $urandom();             // Sparse
            end else if (i % 3 == 1) begin
                onset = onset | $urandom();             // Dense
            end
            start_run(onset);
            wait_done();
            check_run(onset);
        end
    endtask

    task automatic test_start_while_busy();
        logic [31:0] w;
        start_run(32'h6F3A_95C1);
        write_ok(`QM_ADDR_ONSET, ~32'h6F3A_95C1);
        w = '0;
        while (w[`QM_STAT_PCNT_LSB +: `QM_CNT_W] == '0 && !w[`QM_STAT_DONE_BIT]) begin
            read_ok(`QM_ADDR_STATUS, w);                // Until primes are stored
        end
        check_bit("busy with primes stored", w[`QM_STAT_BUSY_BIT], 1'b1);
        write_ok(`QM_ADDR_CTRL, 32'h1);                 // Must be ignored
        wait_done();
        check_run(32'h6F3A_95C1);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'h15b6dd76));
        @(posedge rst_n);
        test_reset_values();
        test_register_access();
        test_corner_onsets();
        test_random_runs();
        test_start_while_busy();
        if (i_qm_top.i_qm_asserts.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d assertion failures seen on the DUT",
                                    i_qm_top.i_qm_asserts.fail_count));
        end
    end

    initial begin
        repeat (NUM_RUNS * RUN_CYCLES) @(posedge clk);
        stop_on_error("Watchdog timeout: a run never reported done");
    end

endmodule

//--- qm_top.f
+incdir+include
src/qm_pkg.sv
src/qm_apb_slave.sv
src/qm_merge_engine.sv
src/qm_prime_chart.sv
src/qm_top.sv
tests/qm_clk_gen.sv
tests/qm_asserts.sv
tests/qm_tb.sv

//--- Bender.yml
package:
  name: qm_top

sources:
  - include_dirs:
      - include
    files:
      - src/qm_pkg.sv
      - src/qm_apb_slave.sv
      - src/qm_merge_engine.sv
      - src/qm_prime_chart.sv
      - src/qm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/qm_clk_gen.sv
      - tests/qm_asserts.sv
      - tests/qm_tb.sv
